//--- kp_consts.svh
`ifndef KP_CONSTS_SVH
`define KP_CONSTS_SVH

// Clock cycles spent on each keypad column
`define KP_SCAN_DIV 8

// Write strobe low time, and again high time, in clock cycles
`define SCREEN_WR_CYCLES 2

// Register byte offsets on the APB side
`define REG_KEY         8'h00
`define REG_STATUS      8'h04
`define REG_SCREEN_CMD  8'h08
`define REG_SCREEN_DATA 8'h0C

// Key that steps the application select
`define APP_KEY 4'd15

`endif

//--- bus_pkg.sv
package bus_pkg;

    // Byte address seen by the register block
    typedef logic [7:0] apb_addr_t;

    // Read and write data word
    typedef logic [31:0] apb_data_t;

endpackage

//--- io_pkg.sv
package io_pkg;

    // One-hot column drive, also used for the row sense lines
    typedef logic [3:0] column_t;

    // Row index times four plus column index
    typedef logic [3:0] key_code_t;

    // Valid flag on top of a key code
    typedef logic [4:0] button_t;

    typedef logic [1:0] app_t;

    typedef logic [7:0] byte_t;

    // Debounce states, judged once per full scan
    typedef enum logic [1:0] {
        scan_idle,
        scan_candidate,
        scan_held
    } scan_state_t;

    // 8080 write cycle phases
    typedef enum logic [1:0] {
        wr_idle,
        wr_low,
        wr_high
    } wr_state_t;

endpackage

//--- screen_if.sv
`timescale 1ns/1ns

interface screen_if;
    import io_pkg::*;

    logic  valid;
    logic  is_data;
    byte_t data;
    logic  ready;

    // Register block side offers bytes
    modport bridge (output valid, output is_data, output data, input ready);

    // Display writer side accepts them
    modport writer (input valid, input is_data, input data, output ready);

endinterface

//--- column_scanner.sv
`timescale 1ns/1ns

`include "kp_consts.svh"

module column_scanner (
    input  logic            clk,
    input  logic            rst,
    output io_pkg::column_t column,
    output logic            step
);
    localparam int div_w = $clog2(`KP_SCAN_DIV);

    logic [div_w-1:0] div_cnt;

    // Last cycle on the current column
    assign step = (div_cnt == div_w'(`KP_SCAN_DIV - 1));

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            column  <= 4'b0001;
        end else if (step) begin
            div_cnt <= '0;
            // Rotate drive to the next column
            column  <= {column[2:0], column[3]};
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

//--- keypad_decoder.sv
`timescale 1ns/1ns

`include "kp_consts.svh"

module keypad_decoder (
    input  logic            clk,
    input  logic            rst,
    input  io_pkg::column_t column,
    input  io_pkg::column_t row,
    input  logic            step,
    output io_pkg::button_t button,
    output logic            rising,
    output io_pkg::app_t    app
);
    import io_pkg::*;

    column_t     row_meta;
    column_t     row_sync;
    logic        scan_seen;
    logic        scan_multi;
    key_code_t   scan_code;
    key_code_t   cand_code;
    logic        col_hit;
    logic        col_single;
    logic        wrap;
    logic        seen_next;
    logic        multi_next;
    logic        single_key;
    key_code_t   code_next;
    scan_state_t state;

    function automatic logic [1:0] onehot_index(input column_t v);
        logic [1:0] idx;
        idx = '0;
        for (int i = 0; i < 4; i++) begin
            if (v[i]) begin
                idx = 2'(i);
            end
        end
        return idx;
    endfunction

    assign col_hit    = |row_sync;
    assign col_single = col_hit && ((row_sync & (row_sync - 4'd1)) == 4'd0);

    // Scan result including the column being sampled now
    assign seen_next  = scan_seen || col_hit;
    assign multi_next = scan_multi || (col_hit && (!col_single || scan_seen));
    assign code_next  = col_hit ? {onehot_index(row_sync), onehot_index(column)} : scan_code;
    assign single_key = seen_next && !multi_next;

    // Last column step closes the scan
    assign wrap = step && column[3];

    // Row synchronizer and key codes
    always_ff @(posedge clk) begin
        row_meta <= row;
        row_sync <= row_meta;
        if (step) begin
            scan_code <= code_next;
        end
        if (wrap && single_key) begin
            cand_code <= code_next;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            scan_seen  <= 1'b0;
            scan_multi <= 1'b0;
        end else if (wrap) begin
            scan_seen  <= 1'b0;
            scan_multi <= 1'b0;
        end else if (step) begin
            scan_seen  <= seen_next;
            scan_multi <= multi_next;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state  <= scan_idle;
            button <= '0;
            rising <= 1'b0;
            app    <= '0;
        end else begin
            rising <= 1'b0;
            if (wrap) begin
                case (state)
                    scan_idle: begin
                        if (single_key) begin
                            state <= scan_candidate;
                        end
                    end
                    scan_candidate: begin
                        if (single_key && code_next == cand_code) begin
                            // Same single key on two scans in a row
                            state  <= scan_held;
                            rising <= 1'b1;
                            button <= {1'b1, code_next};
                            if (code_next == `APP_KEY) begin
                                app <= app + 2'd1;
                            end
                        end else if (!single_key) begin
                            state <= scan_idle;
                        end
                    end
                    scan_held: begin
                        // Needs one empty scan before the next press
                        if (!seen_next) begin
                            state <= scan_idle;
                        end
                    end
                    default: state <= scan_idle;
                endcase
            end
        end
    end

endmodule

//--- screen_writer.sv
`timescale 1ns/1ns

`include "kp_consts.svh"

module screen_writer (
    input  logic            clk,
    input  logic            rst,
    screen_if.writer        bus,
    output logic            csx,
    output logic            dcx,
    output logic            wrx,
    output io_pkg::byte_t   screen_data
);
    import io_pkg::*;

    localparam int cnt_w = $clog2(`SCREEN_WR_CYCLES + 1);

    wr_state_t        state;
    logic [cnt_w-1:0] strobe_cnt;
    logic             strobe_done;
    logic             accept;

    assign bus.ready   = (state == wr_idle);
    assign accept      = bus.valid && bus.ready;
    assign strobe_done = (strobe_cnt == cnt_w'(`SCREEN_WR_CYCLES - 1));

    // Byte and D/C held for the whole chip select window
    always_ff @(posedge clk) begin
        if (accept) begin
            screen_data <= bus.data;
            dcx         <= bus.is_data;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state      <= wr_idle;
            csx        <= 1'b1;
            wrx        <= 1'b1;
            strobe_cnt <= '0;
        end else begin
            case (state)
                wr_idle: begin
                    if (accept) begin
                        state      <= wr_low;
                        csx        <= 1'b0;
                        wrx        <= 1'b0;
                        strobe_cnt <= '0;
                    end
                end
                wr_low: begin
                    if (strobe_done) begin
                        // Rising wrx latches the byte in the LCD
                        state      <= wr_high;
                        wrx        <= 1'b1;
                        strobe_cnt <= '0;
                    end else begin
                        strobe_cnt <= strobe_cnt + 1'b1;
                    end
                end
                wr_high: begin
                    if (strobe_done) begin
                        state      <= wr_idle;
                        csx        <= 1'b1;
                        strobe_cnt <= '0;
                    end else begin
                        strobe_cnt <= strobe_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= wr_idle;
                    csx   <= 1'b1;
                    wrx   <= 1'b1;
                end
            endcase
        end
    end

endmodule

//--- mmio_regs.sv
`timescale 1ns/1ns

`include "kp_consts.svh"

module mmio_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  bus_pkg::apb_addr_t paddr,
    input  bus_pkg::apb_data_t pwdata,
    output bus_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    input  io_pkg::button_t    button,
    input  logic               rising,
    input  io_pkg::app_t       app,
    screen_if.bridge           bus
);
    import io_pkg::*;

    button_t key_q;
    logic    pending;
    logic    access;
    logic    hit_key;
    logic    hit_status;
    logic    hit_cmd;
    logic    hit_data;
    logic    mapped;
    logic    screen_wr;
    logic    key_read;

    assign access     = psel && penable;
    assign hit_key    = (paddr == `REG_KEY);
    assign hit_status = (paddr == `REG_STATUS);
    assign hit_cmd    = (paddr == `REG_SCREEN_CMD);
    assign hit_data   = (paddr == `REG_SCREEN_DATA);
    assign mapped     = hit_key || hit_status || hit_cmd || hit_data;
    assign screen_wr  = pwrite && (hit_cmd || hit_data);

    // Display byte offered only in the access phase
    assign bus.valid   = access && screen_wr;
    assign bus.is_data = hit_data;
    assign bus.data    = pwdata[7:0];

    // Writer back-pressure is the only source of wait states
    assign pready  = access && (screen_wr ? bus.ready : 1'b1);
    assign pslverr = access && !mapped;

    assign key_read = access && !pwrite && hit_key;

    always_comb begin
        case (paddr)
            `REG_KEY:    prdata = {27'd0, key_q};
            `REG_STATUS: prdata = {28'd0, app, !bus.ready, pending};
            default:     prdata = '0;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            key_q   <= '0;
            pending <= 1'b0;
        end else begin
            if (key_read) begin
                pending <= 1'b0;
            end
            // A fresh press wins over a read in the same cycle
            if (rising) begin
                key_q   <= button;
                pending <= 1'b1;
            end
        end
    end

endmodule

//--- soc_io_top.sv
`timescale 1ns/1ns

module soc_io_top (
    input  logic               clk,
    input  logic               rst,
    input  io_pkg::column_t    row,
    output io_pkg::column_t    column,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  bus_pkg::apb_addr_t paddr,
    input  bus_pkg::apb_data_t pwdata,
    output bus_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               screen_csx,
    output logic               screen_dcx,
    output logic               screen_wrx,
    output io_pkg::byte_t      screen_data
);
    import io_pkg::*;

    logic    step;
    button_t button;
    logic    rising;
    app_t    app;

    // Display byte path from registers to the 8080 writer
    screen_if scr_bus ();

    column_scanner u_scanner (
        .clk    (clk),
        .rst    (rst),
        .column (column),
        .step   (step)
    );

    keypad_decoder u_keypad (
        .clk    (clk),
        .rst    (rst),
        .column (column),
        .row    (row),
        .step   (step),
        .button (button),
        .rising (rising),
        .app    (app)
    );

    mmio_regs u_mmio (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .button  (button),
        .rising  (rising),
        .app     (app),
        .bus     (scr_bus.bridge)
    );

    screen_writer u_screen (
        .clk         (clk),
        .rst         (rst),
        .bus         (scr_bus.writer),
        .csx         (screen_csx),
        .dcx         (screen_dcx),
        .wrx         (screen_wrx),
        .screen_data (screen_data)
    );

endmodule

//--- soc_io_properties.sv
`timescale 1ns/1ns

module soc_io_properties (
    input logic            clk,
    input logic            rst,
    input io_pkg::column_t column,
    input logic            psel,
    input logic            penable,
    input logic            pready,
    input logic            pslverr,
    input logic            screen_csx,
    input logic            screen_dcx,
    input logic            screen_wrx,
    input io_pkg::byte_t   screen_data
);

    column_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot(column))
        else $error("column drive is not one-hot");

    // Strobe only inside the chip select window
    wrx_inside_csx: assert property (@(posedge clk) disable iff (rst)
        !screen_wrx |-> !screen_csx)
        else $error("wrx low while csx high");

    screen_bus_stable: assert property (@(posedge clk) disable iff (rst)
        (!screen_csx && !$past(screen_csx)) |-> ($stable(screen_data) && $stable(screen_dcx)))
        else $error("display data or dcx changed during a write");

    slverr_in_access: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> (psel && penable && pready))
        else $error("pslverr outside a completing access");

endmodule

bind soc_io_top soc_io_properties u_props (
    .clk         (clk),
    .rst         (rst),
    .column      (column),
    .psel        (psel),
    .penable     (penable),
    .pready      (pready),
    .pslverr     (pslverr),
    .screen_csx  (screen_csx),
    .screen_dcx  (screen_dcx),
    .screen_wrx  (screen_wrx),
    .screen_data (screen_data)
);

//--- tb_soc_io.sv
`timescale 1ns/1ns

`include "kp_consts.svh"

module tb_soc_io;
    import io_pkg::*;
    import bus_pkg::*;

    localparam int scan_cycles = 4 * `KP_SCAN_DIV;
    // Ten key tests of about seven scans each, display traffic, then a wide margin
    localparam int test_cycles = 10 * 7 * scan_cycles + 200;
    localparam int timeout_cycles = 8 * test_cycles;

    logic      clk;
    logic      rst;
    column_t   row;
    column_t   column;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      screen_csx;
    logic      screen_dcx;
    logic      screen_wrx;
    byte_t     screen_data;

    logic [15:0] keys_held;
    app_t        app_model;
    logic [8:0]  writes_seen[$];
    logic        wrx_prev = 1'b1;
    int          cycle_count = 0;

    soc_io_top DUT (
        .clk         (clk),
        .rst         (rst),
        .row         (row),
        .column      (column),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .screen_csx  (screen_csx),
        .screen_dcx  (screen_dcx),
        .screen_wrx  (screen_wrx),
        .screen_data (screen_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
            $display("Testbench failed");
            $fatal(1);
        end
    end

    // Key (r, c) connects column c to row r while held
    function automatic column_t rows_for(input column_t col, input logic [15:0] held);
        column_t r;
        r = '0;
        for (int i = 0; i < 16; i++) begin
            if (held[i] && col[i % 4]) begin
                r[i / 4] = 1'b1;
            end
        end
        return r;
    endfunction

    initial begin
        row = '0;
        forever begin
            @(posedge clk);
            #1;
            row = rows_for(column, keys_held);
        end
    end

    // Log every falling write strobe as {dcx, data}
    always @(negedge clk) begin
        if (wrx_prev && !screen_wrx) begin
            writes_seen.push_back({screen_dcx, screen_data});
        end
        wrx_prev = screen_wrx;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("Check failed, %s", what);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // Starts and ends 1 ns after a rising edge
    task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err, output int waits);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        waits   = 0;
        @(negedge clk);
        while (!pready) begin
            // A stall means the display writer is busy
            check_value("screen_csx", {31'd0, screen_csx}, 32'h0);
            waits++;
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata,
                             output logic err, output int waits);
        apb_data_t unused;
        apb_access(1'b1, addr, wdata, unused, err, waits);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata, output logic err);
        int waits;
        apb_access(1'b0, addr, '0, rdata, err, waits);
    endtask

    task automatic wait_scans(input int n);
        repeat (n * scan_cycles) @(posedge clk);
        #1;
    endtask

    // Lands on the first cycle of column 0
    task automatic align_scan();
        while (column != 4'b1000) begin
            @(posedge clk);
            #1;
        end
        while (column != 4'b0001) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_screen_idle();
        while (screen_csx !== 1'b1) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic press_and_check(input int r, input int c);
        key_code_t code;
        apb_data_t data;
        logic      err;
        code = 4'(r * 4 + c);
        align_scan();
        keys_held = 16'd1 << code;
        wait_scans(3);
        if (code == `APP_KEY) begin
            app_model = app_model + 2'd1;
        end
        apb_read(`REG_STATUS, data, err);
        check_value("status", data, {28'd0, app_model, 2'b01});
        apb_read(`REG_KEY, data, err);
        check_value("key", data, {27'd0, 1'b1, code});
        apb_read(`REG_STATUS, data, err);
        check_value("status", data, {28'd0, app_model, 2'b00});
        keys_held = '0;
        wait_scans(2);
    endtask

    initial begin
        apb_data_t data;
        logic      err;
        int        waits;
        int        key_a;
        int        key_b;
        byte_t     cmd_byte;
        byte_t     data_a;
        byte_t     data_b;

        void'($urandom(50628));
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        keys_held = '0;
        app_model = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // Reset state
        @(negedge clk);
        check_value("column", {28'd0, column}, 32'h1);
        check_value("screen_csx", {31'd0, screen_csx}, 32'h1);
        check_value("screen_wrx", {31'd0, screen_wrx}, 32'h1);
        check_value("pready", {31'd0, pready}, 32'h0);
        @(posedge clk);
        #1;
        apb_read(`REG_STATUS, data, err);
        check_value("status", data, 32'h0);

        // Single random keys
        for (int i = 0; i < 7; i++) begin
            press_and_check(int'($urandom % 4), int'($urandom % 4));
        end

        // Two keys at once are rejected
        key_a = int'($urandom % 16);
        key_b = (key_a + 1 + int'($urandom % 15)) % 16;
        align_scan();
        keys_held = (16'd1 << key_a) | (16'd1 << key_b);
        wait_scans(3);
        apb_read(`REG_STATUS, data, err);
        check_value("status", data, {28'd0, app_model, 2'b00});
        keys_held = '0;
        wait_scans(2);

        // App key twice steps the select by two
        data_a = {6'd0, app_model};
        press_and_check(3, 3);
        press_and_check(3, 3);
        apb_read(`REG_STATUS, data, err);
        check_value("status app", {30'd0, data[3:2]}, {30'd0, 2'(data_a + 8'd2)});

        // Command then data bytes to the display
        cmd_byte = 8'($urandom());
        data_a   = 8'($urandom());
        data_b   = 8'($urandom());
        writes_seen.delete();
        apb_write(`REG_SCREEN_CMD, {24'd0, cmd_byte}, err, waits);
        check_value("pslverr", {31'd0, err}, 32'h0);
        check_value("wait states", 32'(waits), 32'h0);
        apb_read(`REG_STATUS, data, err);
        check_value("status", data, {28'd0, app_model, 2'b10});
        wait_screen_idle();

        // Back to back writes, the second one stalls
        apb_write(`REG_SCREEN_DATA, {24'd0, data_a}, err, waits);
        check_value("wait states", 32'(waits), 32'h0);
        apb_write(`REG_SCREEN_DATA, {24'd0, data_b}, err, waits);
        check_true(waits > 0, "second display write was not stalled by the busy writer");
        wait_screen_idle();
        check_value("write count", 32'(writes_seen.size()), 32'h3);
        check_value("screen_dcx,screen_data", 32'(writes_seen[0]), {23'd0, 1'b0, cmd_byte});
        check_value("screen_dcx,screen_data", 32'(writes_seen[1]), {23'd0, 1'b1, data_a});
        check_value("screen_dcx,screen_data", 32'(writes_seen[2]), {23'd0, 1'b1, data_b});

        // Unmapped offset
        apb_read(8'h10, data, err);
        check_value("pslverr", {31'd0, err}, 32'h1);
        apb_write(8'h10, 32'h55, err, waits);
        check_value("pslverr", {31'd0, err}, 32'h1);
        wait_scans(1);
        check_value("write count", 32'(writes_seen.size()), 32'h3);
        apb_read(`REG_STATUS, data, err);
        check_value("status", data, {28'd0, app_model, 2'b00});

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- sources.f
+incdir+.
bus_pkg.sv
io_pkg.sv
screen_if.sv
column_scanner.sv
keypad_decoder.sv
screen_writer.sv
mmio_regs.sv
soc_io_top.sv
soc_io_properties.sv
tb_soc_io.sv

//--- run.sh
#!/bin/sh
# Builds and runs the keypad and display testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --assert --top-module tb_soc_io -f sources.f -o sim_soc_io
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_soc_io > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
